// File: source/dispatch_pkg.sv
/*
 * widths shared by the dispatch stage, the functional-unit
 * encoding and the operand word handed to the stations
 */
package dispatch_pkg;

    //////////////////////////////////////////////////
    // datapath and architectural register file
    //////////////////////////////////////////////////

    // data word width
    localparam int xlen = 32;
    // x0 .. x31
    localparam int reg_count = 32;
    localparam int reg_addr_w = 5;

    //////////////////////////////////////////////////
    // functional units
    //////////////////////////////////////////////////

    // value doubles as the bit index into the station vectors
    typedef enum logic [1:0] {
        fu_alu  = 2'd0,
        fu_mult = 2'd1,
        fu_btu  = 2'd2,
        fu_lsu  = 2'd3
    } fu_e;

    localparam int fu_count = 4;

    //////////////////////////////////////////////////
    // operand word
    //////////////////////////////////////////////////

    // widest tag the operand word can carry (256 entries)
    localparam int max_tag_w = 8;

    // ready bit alongside picks the view
    // ready -> value, not ready -> producer tag, zero padded
    typedef union packed {
        logic [xlen-1:0] value;
        struct packed {
            logic [xlen-max_tag_w-1:0] pad;
            logic [max_tag_w-1:0]      tag;
        } tag_view;
    } operand_word;

endpackage

// File: source/dispatch_ctrl.sv
/*
 * dispatch handshake and station choice
 * decides the single transfer enable used by rename and allocation
 */
`timescale 1ns/1ns

module dispatch_ctrl #(
    parameter int rob_depth = 8
) (
    input  logic                                clk,
    input  logic                                reset,

    // decoded instruction side
    input  logic                                in_valid,
    input  dispatch_pkg::fu_e                   in_fu,
    output logic                                in_ready,

    // station and reorder buffer status
    input  logic [dispatch_pkg::fu_count-1:0]   rs_ready,
    input  logic                                rob_full,

    // transfer enables
    output logic                                alloc,
    output logic [dispatch_pkg::fu_count-1:0]   rs_load
);
    import dispatch_pkg::*;

    // tags have to fit the operand word tag view
    if (rob_depth < 2 || rob_depth > (1 << max_tag_w)) begin : g_bad_depth
        $error("dispatch_ctrl: rob_depth must lie between 2 and 256");
    end

    //////////////////////////////////////////////////
    // out of reset flag
    //////////////////////////////////////////////////

    // low through the reset cycle, high from the first cycle after
    logic run;

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    // station picked by the unit field
    logic station_free;

    assign station_free = rs_ready[in_fu];

    // need a free rob slot and a free station of the right kind
    assign in_ready = run & ~rob_full & station_free;

    // one accepted instruction per cycle
    assign alloc = in_valid & in_ready;

    // one-hot load strobe, zero outside a transfer
    assign rs_load = alloc ? (fu_count'(1) << in_fu) : '0;

endmodule

// File: source/map_table.sv
/*
 * register alias table
 * per register busy bit and pending reorder buffer tag
 */
`timescale 1ns/1ns

module map_table #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                                clk,
    input  logic                                reset,

    // rename of the dispatched dest
    input  logic                                alloc,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_dest,
    input  logic [tag_w-1:0]                    alloc_tag,

    // source lookup
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_src1,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_src2,
    output logic                                src1_busy,
    output logic [tag_w-1:0]                    src1_tag,
    output logic                                src2_busy,
    output logic [tag_w-1:0]                    src2_tag,

    // head retirement
    input  logic                                retire_valid,
    input  logic [dispatch_pkg::reg_addr_w-1:0] retire_reg,
    input  logic [tag_w-1:0]                    retire_tag
);
    import dispatch_pkg::*;

    logic [reg_count-1:0] busy;
    logic [tag_w-1:0]     tags [reg_count];
    logic                 rename;
    logic                 clear;

    // x0 is never renamed so it always reads as not busy
    assign rename = alloc && (in_dest != '0);

    // only drop the mapping if nobody renamed the register since
    assign clear = retire_valid && busy[retire_reg] && (tags[retire_reg] == retire_tag);

    //////////////////////////////////////////////////
    // busy bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (clear) begin
                busy[retire_reg] <= 1'b0;
            end
            // later assignment, so a rename beats the clear
            if (rename) begin
                busy[in_dest] <= 1'b1;
            end
        end
    end

    // tag payload, meaningful only while busy
    always_ff @(posedge clk) begin
        if (rename) begin
            tags[in_dest] <= alloc_tag;
        end
    end

    // lookups see the table before this cycle's rename
    assign src1_busy = busy[in_src1];
    assign src1_tag  = tags[in_src1];
    assign src2_busy = busy[in_src2];
    assign src2_tag  = tags[in_src2];

endmodule

// File: source/reorder_buffer.sv
/*
 * circular reorder buffer with in-order retirement
 * entries hold dest, done and result; written by the data bus
 */
`timescale 1ns/1ns

module reorder_buffer #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                                clk,
    input  logic                                reset,

    // allocation at the tail
    input  logic                                alloc,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_dest,
    output logic [tag_w-1:0]                    tail_tag,
    output logic                                full,

    // common data bus
    input  logic                                cdb_valid,
    input  logic [tag_w-1:0]                    cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]       cdb_value,

    // operand read ports
    input  logic [tag_w-1:0]                    rd_tag1,
    input  logic [tag_w-1:0]                    rd_tag2,
    output logic                                rd_done1,
    output logic [dispatch_pkg::xlen-1:0]       rd_value1,
    output logic                                rd_done2,
    output logic [dispatch_pkg::xlen-1:0]       rd_value2,

    // retirement from the head
    output logic                                commit_valid,
    output logic [dispatch_pkg::reg_addr_w-1:0] commit_reg,
    output logic [tag_w-1:0]                    commit_tag,
    output logic [dispatch_pkg::xlen-1:0]       commit_value
);
    import dispatch_pkg::*;

    // entry storage
    logic [reg_addr_w-1:0] dest  [rob_depth];
    logic [xlen-1:0]       value [rob_depth];
    logic                  done  [rob_depth];

    // pointers and occupancy
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;

    // wrap also for depths that are not a power of two
    function automatic logic [tag_w-1:0] bump(input logic [tag_w-1:0] ptr);
        bump = (ptr == tag_w'(rob_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign tail_tag = tail;
    assign full     = (count == (tag_w + 1)'(rob_depth));

    //////////////////////////////////////////////////
    // retirement
    //////////////////////////////////////////////////

    // head leaves as soon as its result is in
    assign commit_valid = (count != '0) && done[head];
    assign commit_reg   = dest[head];
    assign commit_tag   = head;
    assign commit_value = value[head];

    //////////////////////////////////////////////////
    // head, tail and count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= bump(tail);
            end
            if (commit_valid) begin
                head <= bump(head);
            end
            // retire plus allocate leaves count alone
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // entry contents
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // fresh entry starts not done
        if (alloc) begin
            dest[tail] <= in_dest;
            done[tail] <= 1'b0;
        end
        // broadcast result lands in its entry
        if (cdb_valid) begin
            done[cdb_tag]  <= 1'b1;
            value[cdb_tag] <= cdb_value;
        end
    end

    // operand reads for dependent sources
    assign rd_done1  = done[rd_tag1];
    assign rd_value1 = value[rd_tag1];
    assign rd_done2  = done[rd_tag2];
    assign rd_value2 = value[rd_tag2];

endmodule

// File: source/reg_file.sv
/*
 * architectural register file
 * two read ports, one retire write port, x0 hardwired to zero
 */
`timescale 1ns/1ns

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [dispatch_pkg::reg_addr_w-1:0] rd_addr1,
    input  logic [dispatch_pkg::reg_addr_w-1:0] rd_addr2,
    output logic [dispatch_pkg::xlen-1:0]       rd_data1,
    output logic [dispatch_pkg::xlen-1:0]       rd_data2,
    input  logic                                wr_en,
    input  logic [dispatch_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [dispatch_pkg::xlen-1:0]       wr_data
);
    import dispatch_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // architectural state starts at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass, a pending write keeps the map entry busy
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

// File: source/operand_select.sv
/*
 * operand resolution for the dispatched instruction
 * regfile, rob, same-cycle bus bypass or immediate, else tag
 */
`timescale 1ns/1ns

module operand_select #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    // map table lookup
    input  logic                          src1_busy,
    input  logic [tag_w-1:0]              src1_tag,
    input  logic                          src2_busy,
    input  logic [tag_w-1:0]              src2_tag,

    // committed and in-flight values
    input  logic [dispatch_pkg::xlen-1:0] reg_data1,
    input  logic [dispatch_pkg::xlen-1:0] reg_data2,
    input  logic                          rob_done1,
    input  logic [dispatch_pkg::xlen-1:0] rob_value1,
    input  logic                          rob_done2,
    input  logic [dispatch_pkg::xlen-1:0] rob_value2,

    // bus bypass
    input  logic                          cdb_valid,
    input  logic [tag_w-1:0]              cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0] cdb_value,

    // immediate for source 2
    input  logic [dispatch_pkg::xlen-1:0] in_imm,
    input  logic                          in_imm_valid,

    output dispatch_pkg::operand_word     op1,
    output logic                          op1_ready,
    output dispatch_pkg::operand_word     op2,
    output logic                          op2_ready
);
    import dispatch_pkg::*;

    // priority: regfile, finished rob entry, bus this cycle, else wait on tag
    function automatic logic resolve(
        input  logic            busy,
        input  logic [tag_w-1:0] tag,
        input  logic [xlen-1:0] reg_val,
        input  logic            done,
        input  logic [xlen-1:0] rob_val,
        output operand_word     word
    );
        word = '0;
        resolve = 1'b1;
        if (!busy) begin
            word.value = reg_val;
        end else if (done) begin
            word.value = rob_val;
        end else if (cdb_valid && (cdb_tag == tag)) begin
            // producer broadcasting right now
            word.value = cdb_value;
        end else begin
            word.tag_view.tag = max_tag_w'(tag);
            resolve = 1'b0;
        end
    endfunction

    always_comb begin
        op1_ready = resolve(src1_busy, src1_tag, reg_data1, rob_done1, rob_value1, op1);
    end

    // immediate wins for source 2
    always_comb begin
        if (in_imm_valid) begin
            op2       = '0;
            op2.value = in_imm;
            op2_ready = 1'b1;
        end else begin
            op2_ready = resolve(src2_busy, src2_tag, reg_data2, rob_done2, rob_value2, op2);
        end
    end

endmodule

// File: source/dispatch_stage_top.sv
/*
 * dispatch stage top level
 * control, rename, reorder buffer, register file, operand select
 */
`timescale 1ns/1ns

module dispatch_stage_top #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                                clk,
    input  logic                                reset,

    // decoded instruction in
    input  logic                                in_valid,
    output logic                                in_ready,
    input  dispatch_pkg::fu_e                   in_fu,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_dest,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_src1,
    input  logic [dispatch_pkg::reg_addr_w-1:0] in_src2,
    input  logic [dispatch_pkg::xlen-1:0]       in_imm,
    input  logic                                in_imm_valid,

    // reservation stations
    input  logic [dispatch_pkg::fu_count-1:0]   rs_ready,
    output logic [dispatch_pkg::fu_count-1:0]   rs_load,
    output logic [tag_w-1:0]                    rs_tag_dest,
    output dispatch_pkg::operand_word           rs_op1,
    output logic                                rs_op1_ready,
    output dispatch_pkg::operand_word           rs_op2,
    output logic                                rs_op2_ready,

    // common data bus
    input  logic                                cdb_valid,
    input  logic [tag_w-1:0]                    cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]       cdb_value,

    // commit
    output logic                                commit_valid,
    output logic [dispatch_pkg::reg_addr_w-1:0] commit_reg,
    output logic [dispatch_pkg::xlen-1:0]       commit_value
);
    import dispatch_pkg::*;

    // control
    logic                  alloc;
    logic                  rob_full;
    // rename lookup
    logic                  src1_busy;
    logic                  src2_busy;
    logic [tag_w-1:0]      src1_tag;
    logic [tag_w-1:0]      src2_tag;
    // value sources
    logic [xlen-1:0]       reg_data1;
    logic [xlen-1:0]       reg_data2;
    logic                  rob_done1;
    logic                  rob_done2;
    logic [xlen-1:0]       rob_value1;
    logic [xlen-1:0]       rob_value2;
    // retiring tag for the map clear
    logic [tag_w-1:0]      commit_tag;

    //////////////////////////////////////////////////
    // handshake and station choice
    //////////////////////////////////////////////////

    dispatch_ctrl #(.rob_depth(rob_depth)) u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_fu    (in_fu),
        .in_ready (in_ready),
        .rs_ready (rs_ready),
        .rob_full (rob_full),
        .alloc    (alloc),
        .rs_load  (rs_load)
    );

    //////////////////////////////////////////////////
    // rename and in-flight tracking
    //////////////////////////////////////////////////

    // new tag for the dest is the rob tail
    map_table #(.rob_depth(rob_depth)) u_map (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .in_dest      (in_dest),
        .alloc_tag    (rs_tag_dest),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .src1_busy    (src1_busy),
        .src1_tag     (src1_tag),
        .src2_busy    (src2_busy),
        .src2_tag     (src2_tag),
        .retire_valid (commit_valid),
        .retire_reg   (commit_reg),
        .retire_tag   (commit_tag)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_rob (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .in_dest      (in_dest),
        .tail_tag     (rs_tag_dest),
        .full         (rob_full),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .rd_tag1      (src1_tag),
        .rd_tag2      (src2_tag),
        .rd_done1     (rob_done1),
        .rd_value1    (rob_value1),
        .rd_done2     (rob_done2),
        .rd_value2    (rob_value2),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag),
        .commit_value (commit_value)
    );

    // retirement writes architectural state
    reg_file u_rf (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (in_src1),
        .rd_addr2 (in_src2),
        .rd_data1 (reg_data1),
        .rd_data2 (reg_data2),
        .wr_en    (commit_valid),
        .wr_addr  (commit_reg),
        .wr_data  (commit_value)
    );

    //////////////////////////////////////////////////
    // operand packet
    //////////////////////////////////////////////////

    operand_select #(.rob_depth(rob_depth)) u_opsel (
        .src1_busy    (src1_busy),
        .src1_tag     (src1_tag),
        .src2_busy    (src2_busy),
        .src2_tag     (src2_tag),
        .reg_data1    (reg_data1),
        .reg_data2    (reg_data2),
        .rob_done1    (rob_done1),
        .rob_value1   (rob_value1),
        .rob_done2    (rob_done2),
        .rob_value2   (rob_value2),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .in_imm       (in_imm),
        .in_imm_valid (in_imm_valid),
        .op1          (rs_op1),
        .op1_ready    (rs_op1_ready),
        .op2          (rs_op2),
        .op2_ready    (rs_op2_ready)
    );

endmodule

// File: tb/dispatch_stage_assert.sv
/*
 * concurrent assertions on the dispatch handshake and commit rules
 */
`timescale 1ns/1ns

module dispatch_stage_assert (
    input logic       clk,
    input logic       reset,
    input logic       in_valid,
    input logic       in_ready,
    input logic [3:0] rs_load,
    input logic       commit_valid,
    input logic       rob_full
);

    //////////////////////////////////////////////////
    // station load
    //////////////////////////////////////////////////

    // at most one station per cycle
    a_load_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rs_load))
        else $error("rs_load has more than one bit set");

    // load only on a real transfer
    a_load_xfer: assert property (@(posedge clk) disable iff (reset)
        (rs_load != 4'b0000) |-> (in_valid && in_ready))
        else $error("rs_load set outside a transfer");

    //////////////////////////////////////////////////
    // reset and occupancy
    //////////////////////////////////////////////////

    // pointers cleared after the first reset edge
    a_no_commit_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !commit_valid)
        else $error("commit during reset");

    a_full_stall: assert property (@(posedge clk) disable iff (reset)
        rob_full |-> !in_ready)
        else $error("in_ready high with a full reorder buffer");

endmodule

// File: tb/dispatch_stage_tb.sv
/*
 * testbench for the dispatch stage top level
 * clock, reset, records from the test data file, checks and verdict
 */
`timescale 1ns/1ns

module dispatch_stage_tb;
    import dispatch_pkg::*;

    localparam int limit = 50;

    logic clk;
    logic reset;
    logic in_valid, in_ready, in_imm_valid;
    fu_e in_fu;
    logic [4:0] in_dest, in_src1, in_src2;
    logic [31:0] in_imm;
    logic [3:0] rs_ready, rs_load;
    logic [2:0] rs_tag_dest;
    operand_word rs_op1, rs_op2;
    logic rs_op1_ready, rs_op2_ready;
    logic cdb_valid;
    logic [2:0] cdb_tag;
    logic [31:0] cdb_value;
    logic commit_valid;
    logic [4:0] commit_reg;
    logic [31:0] commit_value;

    int checks = 0;
    int errors = 0;
    // commits seen by the monitor as {reg, value}
    logic [36:0] commit_q[$];

    dispatch_stage_top DUT (.*);

    bind dispatch_stage_top dispatch_stage_assert u_assert (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .rs_load(rs_load), .commit_valid(commit_valid), .rob_full(rob_full)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // collect retirements whenever they happen
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            commit_q.push_back({commit_reg, commit_value});
        end
    end

    //////////////////////////////////////////////////
    // record handlers
    //////////////////////////////////////////////////

    // station vector bit for each unit code
    function automatic logic [3:0] station_bit(input int fu);
        case (fu[1:0])
            2'd0:    station_bit = 4'b0001;
            2'd1:    station_bit = 4'b0010;
            2'd2:    station_bit = 4'b0100;
            default: station_bit = 4'b1000;
        endcase
    endfunction

    // record fields fu dest src1 src2 immv imm tag r1 op1 r2 op2 stall xtag xval
    task automatic dispatch_one(input int f[14]);
        int stalled;
        logic bc_on;
        stalled = 0;
        bc_on = 1'b0;
        @(posedge clk);
        in_valid <= 1'b1;
        in_fu <= fu_e'(f[0][1:0]);
        in_dest <= f[1][4:0];
        in_src1 <= f[2][4:0];
        in_src2 <= f[3][4:0];
        in_imm_valid <= f[4][0];
        in_imm <= f[5];
        // no stall means xtag is a same-cycle bypass broadcast
        if (f[11] == 0 && f[12] != 'hff) begin
            cdb_valid <= 1'b1;
            cdb_tag <= f[12][2:0];
            cdb_value <= f[13];
        end
        @(negedge clk);
        while (!in_ready && stalled < limit) begin
            checks++;
            assert (rs_load == 4'b0000)
                else begin
                    $display("Fail %0t: rs_load %b while in_ready low", $time, rs_load);
                    errors++;
                end
            stalled++;
            @(posedge clk);
            if (bc_on) begin
                cdb_valid <= 1'b0;
                bc_on = 1'b0;
            end
            // after the stall count the station frees up and a retire may start
            if (f[11] != 0 && stalled == f[11]) begin
                rs_ready <= 4'hf;
                if (f[12] != 'hff) begin
                    cdb_valid <= 1'b1;
                    cdb_tag <= f[12][2:0];
                    cdb_value <= f[13];
                    bc_on = 1'b1;
                end
            end
            @(negedge clk);
        end
        if (!in_ready) begin
            $display("timeout: dispatch to dest %0d never accepted", f[1]);
            errors++;
        end else begin
            checks++;
            assert (stalled >= f[11] && rs_load == station_bit(f[0])
                    && rs_tag_dest == f[6][2:0])
                else begin
                    $display("Fail %0t: load %b tag %0d stalled %0d", $time,
                             rs_load, rs_tag_dest, stalled);
                    errors++;
                end
            checks++;
            assert (rs_op1_ready == f[7][0] && rs_op1 == f[8]
                    && rs_op2_ready == f[9][0] && rs_op2 == f[10])
                else begin
                    $display("Fail %0t: op1 %b/%h op2 %b/%h", $time,
                             rs_op1_ready, rs_op1, rs_op2_ready, rs_op2);
                    errors++;
                end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_imm_valid <= 1'b0;
        cdb_valid <= 1'b0;
    endtask

    // one-cycle data bus pulse
    task automatic broadcast(input int tag, input int value);
        @(posedge clk);
        cdb_valid <= 1'b1;
        cdb_tag <= tag[2:0];
        cdb_value <= value;
        @(posedge clk);
        cdb_valid <= 1'b0;
    endtask

    task automatic expect_commit(input int rd, input int value);
        int waited;
        waited = 0;
        while (commit_q.size() == 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (commit_q.size() == 0) begin
            $display("timeout: no commit of register %0d seen", rd);
            errors++;
        end else begin
            checks++;
            assert (commit_q[0] == {rd[4:0], value})
                else begin
                    $display("Fail %0t: commit x%0d=%h, expected x%0d=%h", $time,
                             commit_q[0][36:32], commit_q[0][31:0], rd, value);
                    errors++;
                end
            void'(commit_q.pop_front());
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int fd;
        int f[14];
        int kind;
        string line;
        void'($urandom(24914));
        clk = 1'b0;
        reset <= 1'b1;
        in_valid <= 1'b0;
        in_fu <= fu_alu;
        in_dest <= '0;
        in_src1 <= '0;
        in_src2 <= '0;
        in_imm <= '0;
        in_imm_valid <= 1'b0;
        rs_ready <= 4'hf;
        cdb_valid <= 1'b0;
        cdb_tag <= '0;
        cdb_value <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/dispatch_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                if (line.len() > 2 && kind != "#") begin
                    void'($sscanf(line.substr(2, line.len() - 1),
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]));
                    case (kind)
                        "D": dispatch_one(f);
                        "B": broadcast(f[0], f[1]);
                        "S": begin
                            @(posedge clk);
                            rs_ready <= f[0][3:0];
                        end
                        "C": expect_commit(f[0], f[1]);
                        "W": repeat (f[0]) @(posedge clk);
                        default: begin
                            $display("unknown record type in the test data file");
                            errors++;
                        end
                    endcase
                    // random gap between records
                    repeat ($urandom % 3) @(posedge clk);
                end
            end
            $fclose(fd);
        end

        checks++;
        assert (commit_q.size() == 0)
            else begin
                $display("Fail %0t: %0d unexpected commits", $time, commit_q.size());
                errors++;
            end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb/dispatch_testdata.txt
# D fu dest src1 src2 immv imm tag r1 op1 r2 op2 stall xtag xval (xtag ff = none)
# B tag value, S rs mask, C reg value, W cycles; all fields hex
S f
D 0 01 00 05 0 0 0 1 0 1 0 0 ff 0
D 1 02 01 00 0 0 1 0 0 1 0 0 ff 0
D 0 03 02 01 0 0 2 0 1 0 0 0 ff 0
B 2 333
D 0 04 03 02 1 55 3 1 333 1 55 0 ff 0
D 2 05 02 01 0 0 4 1 222 0 0 0 1 222
S d
D 1 06 04 00 0 0 5 0 3 1 0 3 ff 0
B 0 111
C 01 111
C 02 222
C 03 333
B 4 555
B 3 444
C 04 444
C 05 555
B 5 666
C 06 666
W 2
D 0 07 01 03 0 0 6 1 111 1 333 0 ff 0
B 6 777
C 07 777
D 0 08 00 00 0 0 7 1 0 1 0 0 ff 0
D 1 09 00 00 0 0 0 1 0 1 0 0 ff 0
D 2 0a 00 00 0 0 1 1 0 1 0 0 ff 0
D 3 0b 00 00 0 0 2 1 0 1 0 0 ff 0
D 0 0c 00 00 0 0 3 1 0 1 0 0 ff 0
D 1 0d 00 00 0 0 4 1 0 1 0 0 ff 0
D 2 0e 00 00 0 0 5 1 0 1 0 0 ff 0
D 3 0f 00 00 0 0 6 1 0 1 0 0 ff 0
D 0 10 08 00 0 0 7 1 888 1 0 3 7 888
C 08 888
W 4

// File: src.f
source/dispatch_pkg.sv
source/dispatch_ctrl.sv
source/map_table.sv
source/reorder_buffer.sv
source/reg_file.sv
source/operand_select.sv
source/dispatch_stage_top.sv
tb/dispatch_stage_assert.sv
tb/dispatch_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the dispatch stage testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -f src.f \
        --top-module dispatch_stage_tb -o dispatch_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/dispatch_sim > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
    exit 1
fi
exit 0
